/* Makefile */
SRCS := $(shell cat verilog.f)

obj_dir/Vtb_mips_cpu: verilog.f $(SRCS)
	verilator --binary --timing --assert --top-module tb_mips_cpu -f verilog.f -o Vtb_mips_cpu

run: obj_dir/Vtb_mips_cpu
	@out="$$(./obj_dir/Vtb_mips_cpu)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "Simulation completed successfully"

clean:
	rm -rf obj_dir

.PHONY: run clean

/* mips_alu.sv */
module mips_alu (
    input  mips_pkg::alu_op_t              op,
    input  logic [mips_pkg::word_w-1:0]    a,
    input  logic [mips_pkg::word_w-1:0]    b,
    input  logic [mips_pkg::reg_sel_w-1:0] shamt,
    output logic [mips_pkg::word_w-1:0]    result,
    output logic                           zero
);
    import mips_pkg::*;

    always_comb begin
        case (op)
            alu_add:  result = a + b;
            alu_sub:  result = a - b;
            alu_and:  result = a & b;
            alu_or:   result = a | b;
            alu_xor:  result = a ^ b;
            alu_slt:  result = {{(word_w - 1){1'b0}}, $signed(a) < $signed(b)};
            alu_sltu: result = {{(word_w - 1){1'b0}}, a < b};
            alu_sll:  result = b << shamt; // shifts take the value from b
            alu_srl:  result = b >> shamt;
            alu_sra:  result = $unsigned($signed(b) >>> shamt);
            alu_lui:  result = b << 16;     // immediate to the upper half
            default:  result = a + b;
        endcase
    end

    assign zero = (result == '0); // beq and bne compare through subtract

endmodule

/* mips_control.sv */
module mips_control (
    input  logic                        clk,
    input  logic                        arst_n,
    input  logic [mips_pkg::word_w-1:0] instr,
    input  logic                        alu_zero,
    input  logic                        rs_is_zero,
    input  logic                        waitrequest,
    output logic                        read,
    output logic                        write,
    output logic                        active,
    output logic                        pc_load,
    output logic                        ir_load,
    output logic                        mdr_load,
    output logic                        reg_write,
    output logic                        mem_to_reg,
    output logic                        alu_src_imm,
    output logic                        alu_src_shamt,
    output logic                        dest_rt,
    output logic                        branch_taken_en,
    output logic                        jump_en,
    output logic                        jump_reg,
    output logic                        byte_access,
    output logic                        addr_from_alu,
    output mips_pkg::alu_op_t           alu_op
);
    import mips_pkg::*;

    state_t  state;
    state_t  state_next;
    opcode_t opcode;
    funct_t  funct;
    logic    is_load;
    logic    is_store;
    logic    is_branch;
    logic    is_j;
    logic    is_jr;
    logic    writes_reg;
    logic    branch_cond;

    assign opcode = opcode_t'(instr[31:26]);
    assign funct  = funct_t'(instr[5:0]);

    // instruction decode, independent of state
    always_comb begin
        alu_op        = alu_add;
        alu_src_imm   = 1'b1;
        alu_src_shamt = 1'b0;
        dest_rt       = 1'b1;
        byte_access   = 1'b0;
        is_load       = 1'b0;
        is_store      = 1'b0;
        is_branch     = 1'b0;
        is_j          = 1'b0;
        is_jr         = 1'b0;
        writes_reg    = 1'b0;
        case (opcode)
            op_special: begin
                alu_src_imm = 1'b0;
                dest_rt     = 1'b0; // R-type writes rd
                writes_reg  = 1'b1;
                case (funct)
                    fn_sll: begin
                        alu_op        = alu_sll;
                        alu_src_shamt = 1'b1;
                    end
                    fn_srl: begin
                        alu_op        = alu_srl;
                        alu_src_shamt = 1'b1;
                    end
                    fn_sra: begin
                        alu_op        = alu_sra;
                        alu_src_shamt = 1'b1;
                    end
                    fn_jr: begin
                        is_jr      = 1'b1;
                        writes_reg = 1'b0;
                    end
                    fn_addu: alu_op = alu_add;
                    fn_subu: alu_op = alu_sub;
                    fn_and:  alu_op = alu_and;
                    fn_or:   alu_op = alu_or;
                    fn_xor:  alu_op = alu_xor;
                    fn_slt:  alu_op = alu_slt;
                    fn_sltu: alu_op = alu_sltu;
                    default: writes_reg = 1'b0; // unsupported funct runs as a nop
                endcase
            end
            op_j: is_j = 1'b1;
            op_beq, op_bne: begin
                alu_op      = alu_sub;
                alu_src_imm = 1'b0;
                is_branch   = 1'b1;
            end
            op_addiu: writes_reg = 1'b1;
            op_slti: begin
                alu_op     = alu_slt;
                writes_reg = 1'b1;
            end
            op_andi: begin
                alu_op     = alu_and;
                writes_reg = 1'b1;
            end
            op_ori: begin
                alu_op     = alu_or;
                writes_reg = 1'b1;
            end
            op_xori: begin
                alu_op     = alu_xor;
                writes_reg = 1'b1;
            end
            op_lui: begin
                alu_op     = alu_lui;
                writes_reg = 1'b1;
            end
            op_lw:  is_load = 1'b1;
            op_lbu: begin
                is_load     = 1'b1;
                byte_access = 1'b1;
            end
            op_sw:  is_store = 1'b1;
            op_sb: begin
                is_store    = 1'b1;
                byte_access = 1'b1;
            end
            default: ;
        endcase
    end

    assign mem_to_reg  = is_load;
    assign branch_cond = (opcode == op_beq) ? alu_zero : !alu_zero;

    // sequencing and bus strobes
    always_comb begin
        state_next      = state;
        read            = 1'b0;
        write           = 1'b0;
        pc_load         = 1'b0;
        ir_load         = 1'b0;
        mdr_load        = 1'b0;
        reg_write       = 1'b0;
        addr_from_alu   = 1'b0;
        branch_taken_en = 1'b0;
        jump_en         = 1'b0;
        jump_reg        = 1'b0;
        case (state)
            st_fetch: begin
                read = active; // idle until the first edge after reset
                if (active && !waitrequest) begin
                    ir_load    = 1'b1;
                    pc_load    = 1'b1; // pc + 4
                    state_next = st_decode;
                end
            end
            st_decode: state_next = st_execute;
            st_execute: begin
                state_next = st_fetch;
                if (is_load || is_store) begin
                    state_next = st_memory;
                end else if (writes_reg) begin
                    state_next = st_writeback;
                end else if (is_jr) begin
                    if (rs_is_zero) begin
                        state_next = st_halted; // jr $zero ends the program
                    end else begin
                        jump_reg = 1'b1;
                        pc_load  = 1'b1;
                    end
                end else if (is_j) begin
                    jump_en = 1'b1;
                    pc_load = 1'b1;
                end else if (is_branch) begin
                    branch_taken_en = 1'b1;
                    pc_load         = branch_cond;
                end
            end
            st_memory: begin
                addr_from_alu = 1'b1;
                read          = is_load;
                write         = is_store;
                if (!waitrequest) begin
                    mdr_load   = is_load;
                    state_next = is_load ? st_writeback : st_fetch;
                end
            end
            st_writeback: begin
                reg_write  = 1'b1;
                state_next = st_fetch;
            end
            st_halted: ;
            default: state_next = st_fetch;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state  <= st_fetch;
            active <= 1'b0;
        end else begin
            state  <= state_next;
            active <= (state_next != st_halted); // drops with the halt
        end
    end

    a_rd_wr_excl: assert property (@(posedge clk) disable iff (!arst_n)
        !(read && write));

    a_halt_sticky: assert property (@(posedge clk) disable iff (!arst_n)
        state == st_halted |=> state == st_halted);

    a_read_state: assert property (@(posedge clk) disable iff (!arst_n)
        read |-> state inside {st_fetch, st_memory});

endmodule

/* mips_cpu.sv */
module mips_cpu #(
    parameter logic [mips_pkg::word_w-1:0] reset_addr = 32'hBFC0_0000
) (
    input  logic                        clk,
    input  logic                        arst_n,
    input  logic                        waitrequest,
    input  logic [mips_pkg::word_w-1:0] readdata,
    output logic [mips_pkg::word_w-1:0] address,
    output logic                        write,
    output logic                        read,
    output logic [mips_pkg::word_w-1:0] writedata,
    output logic [3:0]                  byteenable,
    output logic                        active,
    output logic [mips_pkg::word_w-1:0] register_v0
);
    import mips_pkg::*;

    logic [word_w-1:0] instr;
    logic              alu_zero;
    logic              rs_is_zero;
    logic              pc_load;
    logic              ir_load;
    logic              mdr_load;
    logic              reg_write;
    logic              mem_to_reg;
    logic              alu_src_imm;
    logic              alu_src_shamt;
    logic              dest_rt;
    logic              branch_taken_en;
    logic              jump_en;
    logic              jump_reg;
    logic              byte_access;
    logic              addr_from_alu;
    alu_op_t           alu_op;

    mips_control control_inst (
        .clk             (clk),
        .arst_n          (arst_n),
        .instr           (instr),
        .alu_zero        (alu_zero),
        .rs_is_zero      (rs_is_zero),
        .waitrequest     (waitrequest),
        .read            (read),
        .write           (write),
        .active          (active),
        .pc_load         (pc_load),
        .ir_load         (ir_load),
        .mdr_load        (mdr_load),
        .reg_write       (reg_write),
        .mem_to_reg      (mem_to_reg),
        .alu_src_imm     (alu_src_imm),
        .alu_src_shamt   (alu_src_shamt),
        .dest_rt         (dest_rt),
        .branch_taken_en (branch_taken_en),
        .jump_en         (jump_en),
        .jump_reg        (jump_reg),
        .byte_access     (byte_access),
        .addr_from_alu   (addr_from_alu),
        .alu_op          (alu_op)
    );

    mips_datapath #(
        .reset_addr (reset_addr)
    ) datapath_inst (
        .clk             (clk),
        .arst_n          (arst_n),
        .readdata        (readdata),
        .pc_load         (pc_load),
        .ir_load         (ir_load),
        .mdr_load        (mdr_load),
        .reg_write       (reg_write),
        .mem_to_reg      (mem_to_reg),
        .alu_src_imm     (alu_src_imm),
        .alu_src_shamt   (alu_src_shamt),
        .dest_rt         (dest_rt),
        .branch_taken_en (branch_taken_en),
        .jump_en         (jump_en),
        .jump_reg        (jump_reg),
        .byte_access     (byte_access),
        .addr_from_alu   (addr_from_alu),
        .alu_op          (alu_op),
        .address         (address),
        .writedata       (writedata),
        .byteenable      (byteenable),
        .instr           (instr),
        .alu_zero        (alu_zero),
        .rs_is_zero      (rs_is_zero),
        .register_v0     (register_v0)
    );

endmodule

/* mips_datapath.sv */
module mips_datapath #(
    parameter logic [mips_pkg::word_w-1:0] reset_addr = 32'hBFC0_0000
) (
    input  logic                        clk,
    input  logic                        arst_n,
    input  logic [mips_pkg::word_w-1:0] readdata,
    input  logic                        pc_load,
    input  logic                        ir_load,
    input  logic                        mdr_load,
    input  logic                        reg_write,
    input  logic                        mem_to_reg,
    input  logic                        alu_src_imm,
    input  logic                        alu_src_shamt,
    input  logic                        dest_rt,
    input  logic                        branch_taken_en,
    input  logic                        jump_en,
    input  logic                        jump_reg,
    input  logic                        byte_access,
    input  logic                        addr_from_alu,
    input  mips_pkg::alu_op_t           alu_op,
    output logic [mips_pkg::word_w-1:0] address,
    output logic [mips_pkg::word_w-1:0] writedata,
    output logic [3:0]                  byteenable,
    output logic [mips_pkg::word_w-1:0] instr,
    output logic                        alu_zero,
    output logic                        rs_is_zero,
    output logic [mips_pkg::word_w-1:0] register_v0
);
    import mips_pkg::*;

    logic [word_w-1:0]    pc;
    logic [word_w-1:0]    pc_next;
    logic [word_w-1:0]    mdr;
    logic [word_w-1:0]    alu_out;
    logic [word_w-1:0]    alu_result;
    logic [word_w-1:0]    rs_data;
    logic [word_w-1:0]    rt_data;
    logic [word_w-1:0]    alu_b;
    logic [word_w-1:0]    imm_ext;
    logic [word_w-1:0]    wb_data;
    logic [word_w-1:0]    mem_addr;
    logic [word_w-1:0]    branch_target;
    logic [word_w-1:0]    jump_target;
    logic [reg_sel_w-1:0] write_sel;
    logic [reg_sel_w-1:0] shamt;
    logic [1:0]           byte_sel;
    logic [7:0]           load_byte;
    logic                 imm_zero_ext;

    // logical immediates are zero-extended, all others sign-extended
    assign imm_zero_ext = alu_op inside {alu_and, alu_or, alu_xor};
    assign imm_ext      = imm_zero_ext ? {16'b0, instr[15:0]} : {{16{instr[15]}}, instr[15:0]};

    assign alu_b      = alu_src_imm ? imm_ext : rt_data;
    assign shamt      = alu_src_shamt ? instr[10:6] : '0;
    assign write_sel  = dest_rt ? instr[20:16] : instr[15:11];
    assign wb_data    = mem_to_reg ? mdr : alu_out;
    assign rs_is_zero = (rs_data == '0);

    // pc already holds pc + 4 when a branch or jump executes
    assign branch_target = pc + {imm_ext[29:0], 2'b00};
    assign jump_target   = {pc[31:28], instr[25:0], 2'b00};

    always_comb begin
        if (jump_reg) begin
            pc_next = rs_data;
        end else if (jump_en) begin
            pc_next = jump_target;
        end else if (branch_taken_en) begin
            pc_next = branch_target;
        end else begin
            pc_next = pc + 32'd4;
        end
    end

    // bus side: word address plus byte lanes
    assign mem_addr   = addr_from_alu ? alu_out : pc;
    assign byte_sel   = mem_addr[1:0];
    assign address    = {mem_addr[31:2], 2'b00};
    assign byteenable = (byte_access && addr_from_alu) ? (4'b0001 << byte_sel) : 4'b1111;
    assign writedata  = byte_access ? {4{rt_data[7:0]}} : rt_data; // sb on every lane
    assign load_byte  = readdata[8 * byte_sel +: 8];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pc    <= reset_addr;
            instr <= '0;
        end else begin
            if (pc_load) begin
                pc <= pc_next;
            end
            if (ir_load) begin
                instr <= readdata;
            end
        end
    end

    always_ff @(posedge clk) begin
        alu_out <= alu_result;
        if (mdr_load) begin
            mdr <= byte_access ? {24'b0, load_byte} : readdata; // lbu zero-extends
        end
    end

    mips_regfile regfile_inst (
        .clk         (clk),
        .arst_n      (arst_n),
        .read_sel_a  (instr[25:21]),
        .read_sel_b  (instr[20:16]),
        .write_sel   (write_sel),
        .write_en    (reg_write),
        .write_data  (wb_data),
        .read_data_a (rs_data),
        .read_data_b (rt_data),
        .register_v0 (register_v0)
    );

    mips_alu alu_inst (
        .op     (alu_op),
        .a      (rs_data),
        .b      (alu_b),
        .shamt  (shamt),
        .result (alu_result),
        .zero   (alu_zero)
    );

    a_fetch_aligned: assert property (@(posedge clk) disable iff (!arst_n)
        ir_load |-> pc[1:0] == 2'b00);

endmodule

/* mips_pkg.sv */
package mips_pkg;

    localparam int word_w    = 32; // data and address width
    localparam int reg_sel_w = 5;  // register select width

    typedef enum logic [5:0] {
        op_special = 6'h00, // R-type, see funct
        op_j       = 6'h02,
        op_beq     = 6'h04,
        op_bne     = 6'h05,
        op_addiu   = 6'h09,
        op_slti    = 6'h0a,
        op_andi    = 6'h0c,
        op_ori     = 6'h0d,
        op_xori    = 6'h0e,
        op_lui     = 6'h0f,
        op_sb      = 6'h28,
        op_lw      = 6'h23,
        op_lbu     = 6'h24,
        op_sw      = 6'h2b
    } opcode_t;

    typedef enum logic [5:0] {
        fn_sll  = 6'h00,
        fn_srl  = 6'h02,
        fn_sra  = 6'h03,
        fn_jr   = 6'h08,
        fn_addu = 6'h21,
        fn_subu = 6'h23,
        fn_and  = 6'h24,
        fn_or   = 6'h25,
        fn_xor  = 6'h26,
        fn_slt  = 6'h2a,
        fn_sltu = 6'h2b
    } funct_t;

    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_xor,
        alu_slt,
        alu_sltu,
        alu_sll,
        alu_srl,
        alu_sra,
        alu_lui
    } alu_op_t;

    typedef enum logic [2:0] {
        st_fetch,
        st_decode,
        st_execute,
        st_memory,
        st_writeback,
        st_halted
    } state_t;

endpackage

/* mips_regfile.sv */
module mips_regfile (
    input  logic                           clk,
    input  logic                           arst_n,
    input  logic [mips_pkg::reg_sel_w-1:0] read_sel_a,
    input  logic [mips_pkg::reg_sel_w-1:0] read_sel_b,
    input  logic [mips_pkg::reg_sel_w-1:0] write_sel,
    input  logic                           write_en,
    input  logic [mips_pkg::word_w-1:0]    write_data,
    output logic [mips_pkg::word_w-1:0]    read_data_a,
    output logic [mips_pkg::word_w-1:0]    read_data_b,
    output logic [mips_pkg::word_w-1:0]    register_v0
);
    import mips_pkg::*;

    logic [word_w-1:0] regs [1:31]; // $zero has no storage

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (write_en && write_sel != '0) begin // writes to $zero are dropped
            regs[write_sel] <= write_data;
        end
    end

    assign read_data_a = (read_sel_a == '0) ? '0 : regs[read_sel_a];
    assign read_data_b = (read_sel_b == '0) ? '0 : regs[read_sel_b];
    assign register_v0 = regs[2]; // $v0 for the testbench

endmodule

/* mips_stimulus.txt */
# test <name> | load <byte addr> <word> | expect_v0 <value>
# expect_write <address> <writedata> <byteenable>, all hex, in bus order
test alu_imm
load 00 24080005
load 04 00084900
load 08 3529000f
load 0c 3c0a1234
load 10 01495823
load 14 0109602a
load 18 016c1026
load 1c 00000008
expect_v0 1233ffa0
test word_mem
load 00 3c08dead
load 04 3508beef
load 08 ac080040
load 0c 8c020040
load 10 00000008
expect_write 00000040 deadbeef f
expect_v0 deadbeef
test byte_mem
load 00 24080011
load 04 a0080050
load 08 24080022
load 0c a0080051
load 10 240800a3
load 14 a0080052
load 18 240800c4
load 1c a0080053
load 20 90090053
load 24 900a0052
load 28 00094a00
load 2c 012a1025
load 30 00021200
load 34 900b0051
load 38 004b1025
load 3c 00000008
expect_write 00000050 11111111 1
expect_write 00000050 22222222 2
expect_write 00000050 a3a3a3a3 4
expect_write 00000050 c4c4c4c4 8
expect_v0 00c4a322
test branch_jump
load 00 24020000
load 04 24080003
load 08 24090003
load 0c 11090001
load 10 24420100
load 14 24420001
load 18 15090001
load 1c 24420002
load 20 15000001
load 24 24420200
load 28 11000001
load 2c 24420004
load 30 0bf0000f
load 34 24420400
load 38 24420800
load 3c 24420008
load 40 3c0abfc0
load 44 354a0050
load 48 01400008
load 4c 24421000
load 50 24420010
load 54 00000008
expect_v0 0000001f
test halt_only
load 00 00000008
expect_v0 00000000

/* tb_mips_cpu.sv */
module tb_mips_cpu;
    timeunit 1ns;
    timeprecision 1ns;

    localparam logic [31:0] reset_addr  = 32'hBFC0_0000;
    localparam int          period_ns   = 100;
    localparam int          cycle_limit = 2000; // per test

    logic        clk;
    logic        arst_n;
    logic        waitrequest;
    logic [31:0] readdata;
    logic [31:0] address;
    logic        write;
    logic        read;
    logic [31:0] writedata;
    logic [3:0]  byteenable;
    logic        active;
    logic [31:0] register_v0;
    logic        load_en;
    logic [31:0] load_addr;
    logic [31:0] load_word;

    string       test_name [$];
    int          load_test [$];
    logic [31:0] load_addr_q [$];
    logic [31:0] load_word_q [$];
    logic [31:0] exp_v0 [$];
    int          ew_test [$];
    logic [31:0] ew_addr [$];
    logic [31:0] ew_data [$];
    logic [3:0]  ew_be [$];
    logic [31:0] got_addr [$];
    logic [31:0] got_data [$];
    logic [3:0]  got_be [$];

    int passed;
    int failed;
    int test_errors;
    int current;
    bit parsed;

    mips_cpu #(
        .reset_addr (reset_addr)
    ) mips_cpu_inst (
        .clk         (clk),
        .arst_n      (arst_n),
        .waitrequest (waitrequest),
        .readdata    (readdata),
        .address     (address),
        .write       (write),
        .read        (read),
        .writedata   (writedata),
        .byteenable  (byteenable),
        .active      (active),
        .register_v0 (register_v0)
    );

    tb_ram ram_inst (
        .clk         (clk),
        .address     (address),
        .read        (read),
        .write       (write),
        .writedata   (writedata),
        .byteenable  (byteenable),
        .readdata    (readdata),
        .waitrequest (waitrequest),
        .load_en     (load_en),
        .load_addr   (load_addr),
        .load_word   (load_word)
    );

    initial begin
        clk = 1'b0;
        forever #(period_ns / 2) clk = ~clk;
    end

    // every completed bus write, seen with the values before the edge
    always @(posedge clk) begin
        if (arst_n && write && !waitrequest) begin
            got_addr.push_back(address);
            got_data.push_back(writedata);
            got_be.push_back(byteenable);
        end
    end

    initial begin
        wait (parsed && test_name.size() > 0);
        #(test_name.size() * cycle_limit * period_ns);
        $display("timeout: test %s did not halt in time", test_name[current]);
        $display("Simulation failed");
        $finish;
    end

    task automatic read_stimulus();
        int          fd;
        int          code;
        string       kw;
        string       rest;
        logic [31:0] a;
        logic [31:0] d;
        logic [3:0]  be;
        fd = $fopen("mips_stimulus.txt", "r");
        if (fd == 0) begin
            $display("cannot open the stimulus file mips_stimulus.txt");
            failed++;
        end else begin
            while (!$feof(fd)) begin
                code = $fscanf(fd, "%s", kw);
                if (code != 1) break;
                if (kw.getc(0) == 8'h23) begin // comment runs to end of line
                    void'($fgets(rest, fd));
                end else if (kw == "test") begin
                    code = $fscanf(fd, "%s", kw);
                    test_name.push_back(kw);
                end else if (kw == "load") begin
                    code = $fscanf(fd, "%h %h", a, d);
                    load_test.push_back(test_name.size() - 1);
                    load_addr_q.push_back(a);
                    load_word_q.push_back(d);
                end else if (kw == "expect_v0") begin
                    code = $fscanf(fd, "%h", d);
                    exp_v0.push_back(d);
                end else if (kw == "expect_write") begin
                    code = $fscanf(fd, "%h %h %h", a, d, be);
                    ew_test.push_back(test_name.size() - 1);
                    ew_addr.push_back(a);
                    ew_data.push_back(d);
                    ew_be.push_back(be);
                end else begin
                    $display("unknown record %s in the stimulus file", kw);
                    failed++;
                end
            end
            $fclose(fd);
            if (exp_v0.size() != test_name.size()) begin
                $display("stimulus file has %0d tests but %0d expect_v0 records",
                         test_name.size(), exp_v0.size());
                failed++;
            end
        end
    endtask

    task automatic run_test(input int idx);
        int          n;
        int          k;
        logic [31:0] xa [$];
        logic [31:0] xd [$];
        logic [3:0]  xb [$];
        test_errors = 0;
        got_addr.delete();
        got_data.delete();
        got_be.delete();
        @(negedge clk);
        arst_n = 1'b0;
        for (int i = 0; i < load_test.size(); i++) begin
            if (load_test[i] == idx) begin
                load_en   = 1'b1;
                load_addr = load_addr_q[i];
                load_word = load_word_q[i];
                @(negedge clk);
            end
        end
        load_en = 1'b0;
        repeat (2) begin
            @(negedge clk);
            if (read || write || active) begin
                $display("bus or active not idle during reset at t=%0t", $time);
                test_errors++;
            end
        end
        arst_n = 1'b1;
        n = 0;
        while (!active && n < 2) begin
            @(negedge clk);
            n++;
        end
        if (!active) begin
            $display("active did not rise within 2 cycles after reset at t=%0t", $time);
            test_errors++;
        end else if (!read) begin
            $display("first fetch read not issued after reset at t=%0t", $time);
            test_errors++;
        end else if (address !== reset_addr) begin
            $display("FAILED t=%0t address got %h expected %h", $time, address, reset_addr);
            test_errors++;
        end
        while (active) @(negedge clk); // watchdog covers a hang here
        if (register_v0 !== exp_v0[idx]) begin
            $display("FAILED t=%0t register_v0 got %h expected %h",
                     $time, register_v0, exp_v0[idx]);
            test_errors++;
        end
        // halted means no more bus traffic
        repeat (20) begin
            @(negedge clk);
            if (read || write || active) begin
                $display("bus activity after halt at t=%0t", $time);
                test_errors++;
            end
        end
        for (int i = 0; i < ew_test.size(); i++) begin
            if (ew_test[i] == idx) begin
                xa.push_back(ew_addr[i]);
                xd.push_back(ew_data[i]);
                xb.push_back(ew_be[i]);
            end
        end
        if (got_addr.size() != xa.size()) begin
            $display("expected %0d bus writes but saw %0d", xa.size(), got_addr.size());
            test_errors++;
        end
        k = (got_addr.size() < xa.size()) ? got_addr.size() : xa.size();
        for (int i = 0; i < k; i++) begin
            if (got_addr[i] !== xa[i]) begin
                $display("FAILED t=%0t address got %h expected %h", $time, got_addr[i], xa[i]);
                test_errors++;
            end
            if (got_data[i] !== xd[i]) begin
                $display("FAILED t=%0t writedata got %h expected %h",
                         $time, got_data[i], xd[i]);
                test_errors++;
            end
            if (got_be[i] !== xb[i]) begin
                $display("FAILED t=%0t byteenable got %h expected %h", $time, got_be[i], xb[i]);
                test_errors++;
            end
        end
    endtask

    initial begin
        arst_n    = 1'b0;
        load_en   = 1'b0;
        load_addr = '0;
        load_word = '0;
        passed    = 0;
        failed    = 0;
        current   = 0;
        read_stimulus();
        parsed = 1'b1;
        for (int i = 0; i < test_name.size(); i++) begin
            current = i;
            run_test(i);
            if (test_errors == 0) begin
                $display("test %s passed", test_name[i]);
                passed++;
            end else begin
                $display("test %s failed with %0d errors", test_name[i], test_errors);
                failed++;
            end
        end
        $display("%0d tests passed, %0d tests failed", passed, failed);
        if (failed == 0 && passed > 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

/* tb_ram.sv */
module tb_ram (
    input  logic        clk,
    input  logic [31:0] address,
    input  logic        read,
    input  logic        write,
    input  logic [31:0] writedata,
    input  logic [3:0]  byteenable,
    output logic [31:0] readdata,
    output logic        waitrequest,
    input  logic        load_en,
    input  logic [31:0] load_addr,
    input  logic [31:0] load_word
);
    timeunit 1ns;
    timeprecision 1ns;

    logic [31:0] mem [0:63]; // only address bits 7 to 2 are decoded

    initial begin
        for (int i = 0; i < 64; i++) begin
            mem[i[5:0]] <= 32'hcafe_0000 | (i << 2); // fill holds the byte address
        end
    end

    // random back-pressure, changed between rising edges
    initial begin
        void'($urandom(32'h1dee));
        waitrequest = 1'b0;
        forever begin
            @(negedge clk);
            waitrequest = (($urandom() % 5) < 2);
        end
    end

    assign readdata = read ? mem[address[7:2]] : '0; // valid while read is high

    always @(posedge clk) begin
        if (load_en) begin
            mem[load_addr[7:2]] <= load_word;
        end else if (write && !waitrequest) begin
            for (int b = 0; b < 4; b++) begin
                if (byteenable[b]) begin
                    mem[address[7:2]][8 * b +: 8] <= writedata[8 * b +: 8];
                end
            end
        end
    end

endmodule

/* verilog.f */
mips_pkg.sv
mips_regfile.sv
mips_alu.sv
mips_control.sv
mips_datapath.sv
mips_cpu.sv
tb_ram.sv
tb_mips_cpu.sv
